// File: Bender.yml
package:
  name: zap_bus_front

sources:
  - rtl/zap_bus_pkg.sv
  - rtl/zap_mmu_pkg.sv
  - rtl/zap_fcse_xlate.sv
  - rtl/zap_be32_lane.sv
  - rtl/zap_wb_merger.sv
  - rtl/zap_bus_front.sv
  - target: test
    files:
      - testbench/tb_zap_bus_front.sv

// File: all.f
rtl/zap_bus_pkg.sv
rtl/zap_mmu_pkg.sv
rtl/zap_fcse_xlate.sv
rtl/zap_be32_lane.sv
rtl/zap_wb_merger.sv
rtl/zap_bus_front.sv
testbench/tb_zap_bus_front.sv

// File: rtl/zap_be32_lane.sv
// BE-32 byte lane swap on the data channel: select order out, read byte order back.
module zap_be32_lane #(
        parameter bit BE_32_ENABLE = 1'b0
) (
        input  logic                    i_clk,
        input  logic                    i_arst_n,

        input  logic                    i_valid,
        output logic                    o_ready,
        input  zap_bus_pkg::core_req_t  i_req,

        output logic                    o_valid,
        input  logic                    i_ready,
        output zap_bus_pkg::core_req_t  o_req,

        input  zap_bus_pkg::rsp_t       i_rsp,
        output zap_bus_pkg::rsp_t       o_rsp
);

        localparam int unsigned lanes = zap_bus_pkg::sel_w;

        logic [lanes-1:0]               sel_swap;
        logic [lanes-1:0]               sel_q;          // Bus order selects of the last read.
        logic [zap_bus_pkg::dat_w-1:0]  dat_swap;

        // Handshake passes straight through.
        assign o_valid = i_valid;
        assign o_ready = i_ready;

        // --------------------------------------------------------------------------
        // Request path.
        // --------------------------------------------------------------------------

        always_comb
        begin
                for (int i = 0; i < lanes; i++)
                begin
                        sel_swap[i] = i_req.sel[lanes-1-i];
                end
                o_req = i_req;                          // Store data is replicated already.
                if (BE_32_ENABLE)
                begin
                        o_req.sel = sel_swap;
                end
        end

        // Only one data read is ever past this point, so one entry will do.
        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        sel_q <= '0;
                end
                else if (i_valid && i_ready && !i_req.we)
                begin
                        sel_q <= sel_swap;
                end
        end

        // --------------------------------------------------------------------------
        // Response path.
        // --------------------------------------------------------------------------

        always_comb
        begin
                for (int i = 0; i < lanes; i++)
                begin
                        // Core byte i sits on bus lane lanes-1-i; unselected lanes read zero.
                        dat_swap[8*i +: 8] = sel_q[lanes-1-i] ?
                                             i_rsp.dat[8*(lanes-1-i) +: 8] : 8'h00;
                end
                o_rsp = i_rsp;
                if (BE_32_ENABLE)
                begin
                        o_rsp.dat = dat_swap;
                end
        end

endmodule

// File: rtl/zap_bus_front.sv
// Bus front end top: FCSE stages on code and data, BE-32 lane swap, Wishbone merge.
module zap_bus_front #(
        parameter bit BE_32_ENABLE = 1'b0
) (
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        input  zap_mmu_pkg::pid_t               i_pid,

        // Instruction fetch.
        input  logic                            i_code_valid,
        output logic                            o_code_ready,
        input  zap_mmu_pkg::va_u                i_code_adr,
        output zap_bus_pkg::rsp_t               o_code_rsp,

        // Loads and stores.
        input  logic                            i_data_valid,
        output logic                            o_data_ready,
        input  zap_bus_pkg::core_req_t          i_data_req,
        output zap_bus_pkg::rsp_t               o_data_rsp,

        // Wishbone master.
        output zap_bus_pkg::wb_req_t            o_wb,
        input  logic                            i_wb_ack,
        input  logic [zap_bus_pkg::dat_w-1:0]   i_wb_dat
);

        zap_bus_pkg::core_req_t code_req;
        logic                   code_x_valid;
        logic                   code_x_ready;
        zap_bus_pkg::core_req_t code_x_req;
        logic                   data_x_valid;
        logic                   data_x_ready;
        zap_bus_pkg::core_req_t data_x_req;
        logic                   lane_valid;
        logic                   lane_ready;
        zap_bus_pkg::core_req_t lane_req;
        zap_bus_pkg::rsp_t      merge_d_rsp;

        assign code_req = '{adr: i_code_adr.flat, we: 1'b0, sel: '1, dat: '0};

        // --------------------------------------------------------------------------
        // Relocation stages.
        // --------------------------------------------------------------------------

        zap_fcse_xlate #(.WORD_ALIGN(1'b1)) u_code_xlate (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_valid        (i_code_valid),
                .o_ready        (o_code_ready),
                .i_req          (code_req),
                .i_pid          (i_pid),
                .o_valid        (code_x_valid),
                .i_ready        (code_x_ready),
                .o_req          (code_x_req)
        );

        zap_fcse_xlate #(.WORD_ALIGN(1'b0)) u_data_xlate (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_valid        (i_data_valid),
                .o_ready        (o_data_ready),
                .i_req          (i_data_req),
                .i_pid          (i_pid),
                .o_valid        (data_x_valid),
                .i_ready        (data_x_ready),
                .o_req          (data_x_req)
        );

        zap_be32_lane #(.BE_32_ENABLE(BE_32_ENABLE)) u_be32 (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_valid        (data_x_valid),
                .o_ready        (data_x_ready),
                .i_req          (data_x_req),
                .o_valid        (lane_valid),
                .i_ready        (lane_ready),
                .o_req          (lane_req),
                .i_rsp          (merge_d_rsp),
                .o_rsp          (o_data_rsp)
        );

        // --------------------------------------------------------------------------
        // Bus merge.
        // --------------------------------------------------------------------------

        zap_wb_merger u_merger (
                .i_clk          (i_clk),
                .i_arst_n       (i_arst_n),
                .i_c_valid      (code_x_valid),
                .o_c_ready      (code_x_ready),
                .i_c_req        (code_x_req),
                .i_d_valid      (lane_valid),
                .o_d_ready      (lane_ready),
                .i_d_req        (lane_req),
                .o_c_rsp        (o_code_rsp),
                .o_d_rsp        (merge_d_rsp),
                .o_wb           (o_wb),
                .i_wb_ack       (i_wb_ack),
                .i_wb_dat       (i_wb_dat)
        );

endmodule

// File: rtl/zap_bus_pkg.sv
// Bus types for the front end: core requests, Wishbone master outputs and read responses.
package zap_bus_pkg;

        // --------------------------------------------------------------------------
        // Widths.
        // --------------------------------------------------------------------------

        localparam int unsigned adr_w = 32;     // Byte address.
        localparam int unsigned dat_w = 32;     // One word.
        localparam int unsigned sel_w = 4;      // One select per byte lane.

        // Wishbone registered feedback cycle type.
        typedef enum logic [2:0] {
                cti_classic = 3'b000,
                cti_eob     = 3'b111            // End of burst.
        } cti_e;

        typedef enum logic [1:0] {
                bte_linear = 2'b00
        } bte_e;

        // --------------------------------------------------------------------------
        // Bundles.
        // --------------------------------------------------------------------------

        // Request as the core issues it.
        typedef struct packed {
                logic [adr_w-1:0]       adr;
                logic                   we;
                logic [sel_w-1:0]       sel;
                logic [dat_w-1:0]       dat;    // Store data, bytes already replicated.
        } core_req_t;

        typedef struct packed {
                logic                   cyc;
                logic                   stb;
                logic                   we;
                logic [sel_w-1:0]       sel;
                logic [adr_w-1:0]       adr;
                logic [dat_w-1:0]       dat;
                cti_e                   cti;
                bte_e                   bte;
        } wb_req_t;

        // One-cycle read return toward the core.
        typedef struct packed {
                logic                   valid;
                logic [dat_w-1:0]       dat;
        } rsp_t;

endpackage

// File: rtl/zap_fcse_xlate.sv
// Request register stage that relocates low addresses into the process ID region.
module zap_fcse_xlate #(
        parameter bit WORD_ALIGN = 1'b0
) (
        input  logic                    i_clk,
        input  logic                    i_arst_n,

        input  logic                    i_valid,
        output logic                    o_ready,
        input  zap_bus_pkg::core_req_t  i_req,
        input  zap_mmu_pkg::pid_t       i_pid,

        output logic                    o_valid,
        input  logic                    i_ready,
        output zap_bus_pkg::core_req_t  o_req
);

        logic                           full_q;
        logic                           live_q;         // Set on the first edge out of reset.
        logic                           take;
        zap_mmu_pkg::va_u               va_in;
        zap_mmu_pkg::va_u               va_out;
        zap_bus_pkg::core_req_t         req_nxt;

        assign o_valid = full_q;
        assign o_ready = live_q && (!full_q || i_ready); // Empty, or drained this cycle.
        assign take    = i_valid && o_ready;

        // Only region 0 is relocated.
        always_comb
        begin
                va_in.flat = i_req.adr;
                va_out     = va_in;
                if (va_in.fcse.region == '0)
                begin
                        va_out.fcse.region = i_pid;
                end
                if (WORD_ALIGN)
                begin
                        va_out.flat[1:0] = 2'b00;       // Fetches are whole words.
                end
                req_nxt     = i_req;
                req_nxt.adr = va_out.flat;
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        live_q <= 1'b0;
                        full_q <= 1'b0;
                end
                else
                begin
                        live_q <= 1'b1;
                        if (take)
                        begin
                                full_q <= 1'b1;
                        end
                        else if (i_ready)
                        begin
                                full_q <= 1'b0;
                        end
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (take)
                begin
                        o_req <= req_nxt;
                end
        end

endmodule

// File: rtl/zap_mmu_pkg.sv
// Fast context switch types: process ID and the two views of a virtual address.
package zap_mmu_pkg;

        localparam int unsigned region_w = 7;   // Top field that takes the process ID.
        localparam int unsigned offset_w = 25;

        // Process ID, one region of 32 MB each.
        typedef logic [region_w-1:0] pid_t;

        // --------------------------------------------------------------------------
        // Address views.
        // --------------------------------------------------------------------------

        typedef struct packed {
                logic [region_w-1:0]    region;
                logic [offset_w-1:0]    offset;
        } fcse_va_t;

        // Same word, either as a plain bus address or split for relocation.
        typedef union packed {
                logic [region_w+offset_w-1:0]   flat;
                fcse_va_t                       fcse;
        } va_u;

endpackage

// File: rtl/zap_wb_merger.sv
// Round-robin merge of the code and data channels onto one Wishbone master.
module zap_wb_merger (
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        // Code channel.
        input  logic                            i_c_valid,
        output logic                            o_c_ready,
        input  zap_bus_pkg::core_req_t          i_c_req,

        // Data channel.
        input  logic                            i_d_valid,
        output logic                            o_d_ready,
        input  zap_bus_pkg::core_req_t          i_d_req,

        output zap_bus_pkg::rsp_t               o_c_rsp,
        output zap_bus_pkg::rsp_t               o_d_rsp,

        // Wishbone master.
        output zap_bus_pkg::wb_req_t            o_wb,
        input  logic                            i_wb_ack,
        input  logic [zap_bus_pkg::dat_w-1:0]   i_wb_dat
);

        logic                           busy_q;         // A cycle is open on the bus.
        logic                           owner_d_q;      // Channel granted last, 1 is data.
        logic                           c_vld_q;
        logic                           d_vld_q;
        logic [zap_bus_pkg::dat_w-1:0]  rsp_dat_q;
        zap_bus_pkg::core_req_t         req_q;
        zap_bus_pkg::core_req_t         code_req;
        logic                           pick_d;
        logic                           grant;
        logic                           done;

        // --------------------------------------------------------------------------
        // Arbitration.
        // --------------------------------------------------------------------------

        // Data wins when alone, or on a tie after a code grant.
        assign pick_d = i_d_valid && (!i_c_valid || !owner_d_q);
        assign grant  = !busy_q && (i_c_valid || i_d_valid);
        assign done   = busy_q && i_wb_ack;

        assign o_d_ready = !busy_q && pick_d;
        assign o_c_ready = !busy_q && !pick_d;

        // Fetches are always full word reads.
        always_comb
        begin
                code_req     = '0;
                code_req.adr = i_c_req.adr;
                code_req.we  = 1'b0;
                code_req.sel = '1;
        end

        always_ff @(posedge i_clk or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        busy_q    <= 1'b0;
                        owner_d_q <= 1'b0;              // Last served is code.
                        c_vld_q   <= 1'b0;
                        d_vld_q   <= 1'b0;
                end
                else
                begin
                        c_vld_q <= done && !owner_d_q && !req_q.we;
                        d_vld_q <= done &&  owner_d_q && !req_q.we;
                        if (done)
                        begin
                                busy_q <= 1'b0;
                        end
                        else if (grant)
                        begin
                                busy_q    <= 1'b1;
                                owner_d_q <= pick_d;
                        end
                end
        end

        // --------------------------------------------------------------------------
        // Payload.
        // --------------------------------------------------------------------------

        always_ff @(posedge i_clk)
        begin
                if (grant)
                begin
                        req_q <= pick_d ? i_d_req : code_req;
                end
                if (done)
                begin
                        rsp_dat_q <= i_wb_dat;
                end
        end

        // Single-beat cycles only.
        always_comb
        begin
                o_wb.cyc = busy_q;
                o_wb.stb = busy_q;
                o_wb.we  = req_q.we;
                o_wb.sel = req_q.sel;
                o_wb.adr = req_q.adr;
                o_wb.dat = req_q.dat;
                o_wb.cti = zap_bus_pkg::cti_eob;
                o_wb.bte = zap_bus_pkg::bte_linear;
        end

        // Both channels share the data register, only one valid at a time.
        always_comb
        begin
                o_c_rsp.valid = c_vld_q;
                o_c_rsp.dat   = rsp_dat_q;
                o_d_rsp.valid = d_vld_q;
                o_d_rsp.dat   = rsp_dat_q;
        end

endmodule

// File: testbench/tb_zap_bus_front.sv
// Bus front end testbench with random core traffic, a Wishbone slave and a reference model.
module tb_zap_bus_front;

        logic                           clk;
        logic                           arst_n;
        zap_mmu_pkg::pid_t              pid;
        logic                           code_valid;
        logic                           code_ready;
        zap_mmu_pkg::va_u               code_adr;
        zap_bus_pkg::rsp_t              code_rsp;
        logic                           data_valid;
        logic                           data_ready;
        zap_bus_pkg::core_req_t         data_req;
        zap_bus_pkg::rsp_t              data_rsp;
        zap_bus_pkg::wb_req_t           wb;
        logic                           wb_ack;
        logic [31:0]                    wb_dat;

        zap_bus_pkg::wb_req_t           exp_c_q[$];     // Accepted, not yet seen on the bus.
        zap_bus_pkg::wb_req_t           exp_d_q[$];
        logic [3:0]                     core_sel_q[$];  // Core order selects per data request.
        zap_bus_pkg::rsp_t              nxt_c;
        zap_bus_pkg::rsp_t              nxt_d;
        zap_bus_pkg::wb_req_t           wb_prev;
        bit                             held;
        bit                             code_fire;
        bit                             data_fire;
        bit                             fair_mode;
        bit                             run_ok;
        int                             last_chan;
        int                             code_left;
        int                             data_left;
        int                             pct;
        int                             max_wait = 4;
        int                             wait_left;
        int                             errors;
        int                             checks;
        int                             tests;
        int                             test_start;

        zap_bus_front #(.BE_32_ENABLE(1'b1)) dut0 (
                .i_clk          (clk),
                .i_arst_n       (arst_n),
                .i_pid          (pid),
                .i_code_valid   (code_valid),
                .o_code_ready   (code_ready),
                .i_code_adr     (code_adr),
                .o_code_rsp     (code_rsp),
                .i_data_valid   (data_valid),
                .o_data_ready   (data_ready),
                .i_data_req     (data_req),
                .o_data_rsp     (data_rsp),
                .o_wb           (wb),
                .i_wb_ack       (wb_ack),
                .i_wb_dat       (wb_dat)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // --------------------------------------------------------------------------
        // Reference rules.
        // --------------------------------------------------------------------------

        // Region 0 takes the process ID; fetches lose the two low bits.
        function automatic logic [31:0] reloc(input logic [31:0] a, input logic [6:0] p,
                                              input bit align);
                logic [31:0] r;
                r = a;
                if (a[31:25] == 7'd0)
                        r[31:25] = p;
                if (align)
                        r[1:0] = 2'b00;
                return r;
        endfunction

        function automatic logic [3:0] rev_sel(input logic [3:0] s);
                return {s[0], s[1], s[2], s[3]};
        endfunction

        // Core byte i comes from bus lane 3-i and reads zero when not selected.
        function automatic logic [31:0] swap_rd(input logic [31:0] d, input logic [3:0] s);
                logic [31:0] r;
                for (int i = 0; i < 4; i++)
                        r[8*i +: 8] = s[i] ? d[8*(3-i) +: 8] : 8'h00;
                return r;
        endfunction

        function automatic logic [31:0] rand_adr();
                logic [31:0] a;
                a = $urandom;
                if ($urandom_range(1) == 1)
                        a[31:25] = 7'd0;                // Half of them get relocated.
                return a;
        endfunction

        function automatic bit idle();
                return exp_c_q.size() == 0 && exp_d_q.size() == 0 && !nxt_c.valid &&
                       !nxt_d.valid && !code_valid && !data_valid;
        endfunction

        // --------------------------------------------------------------------------
        // Checks and reporting.
        // --------------------------------------------------------------------------

        task automatic check_wb(input string name, input zap_bus_pkg::wb_req_t exp_v,
                                input zap_bus_pkg::wb_req_t act);
                checks++;
                if (act !== exp_v)
                begin
                        errors++;
                        $display("Error at %0t: %s expected %h got %h", $time, name, exp_v, act);
                end
        endtask

        // Data is only compared while a response is due.
        task automatic check_rsp(input string name, input zap_bus_pkg::rsp_t exp_v,
                                 input zap_bus_pkg::rsp_t act);
                checks++;
                if (exp_v.valid ? (act !== exp_v) : (act.valid !== 1'b0))
                begin
                        errors++;
                        $display("Error at %0t: %s expected %h got %h", $time, name, exp_v, act);
                end
        endtask

        task automatic check_field(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act);
                checks++;
                if (act !== exp_v)
                begin
                        errors++;
                        $display("Error at %0t: %s expected %h got %h", $time, name, exp_v, act);
                end
        endtask

        task automatic report_test(input string name);
                tests++;
                $display("Test %0d %s: %s, %0d errors", tests, name,
                         (errors == test_start) ? "ok" : "FAILED", errors - test_start);
                test_start = errors;
        endtask

        task automatic end_run();
                $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
                if (errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        endtask

        task automatic report_timeout(input string what);
                errors++;
                $display("Timeout: %s", what);
        endtask

        // --------------------------------------------------------------------------
        // Stimulus and Wishbone slave driven just after the rising edge.
        // --------------------------------------------------------------------------

        always @(posedge clk)
        begin
                #2;
                if (wb_ack)
                        wb_ack = 1'b0;                  // Cycle closed on this edge.
                else if (wb.stb)
                begin
                        if (wait_left == 0)
                        begin
                                wb_ack    = 1'b1;
                                wb_dat    = $urandom;
                                wait_left = $urandom_range(max_wait);
                        end
                        else
                                wait_left--;
                end
                if (idle())
                        pid = $urandom_range(127);
                if (!code_valid || code_fire)
                begin
                        code_valid = 1'b0;
                        if (code_left > 0 && $urandom_range(99) < pct)
                        begin
                                code_valid    = 1'b1;
                                code_adr.flat = rand_adr();
                                code_left--;
                        end
                end
                if (!data_valid || data_fire)
                begin
                        data_valid = 1'b0;
                        if (data_left > 0 && $urandom_range(99) < pct)
                        begin
                                data_valid   = 1'b1;
                                data_req.adr = rand_adr();
                                data_req.we  = $urandom_range(1);
                                data_req.sel = $urandom_range(15, 1);
                                data_req.dat = $urandom | 32'h1;        // Never a fetch's zero.
                                data_left--;
                        end
                end
        end

        // --------------------------------------------------------------------------
        // Model and monitor sampled at the falling edge.
        // --------------------------------------------------------------------------

        task automatic bus_done();
                zap_bus_pkg::wb_req_t exp_req;
                logic [3:0] s;
                int chan;
                chan = -1;
                // Only fetches carry zero write data.
                if (wb.dat === 32'h0)
                begin
                        if (exp_c_q.size() > 0)
                        begin
                                chan = 0;
                                check_wb("o_wb", exp_c_q.pop_front(), wb);
                                nxt_c = '{valid: 1'b1, dat: wb_dat};
                        end
                end
                else if (exp_d_q.size() > 0)
                begin
                        chan    = 1;
                        exp_req = exp_d_q.pop_front();
                        s       = core_sel_q.pop_front();
                        check_wb("o_wb", exp_req, wb);
                        if (!exp_req.we)
                                nxt_d = '{valid: 1'b1, dat: swap_rd(wb_dat, s)};
                end
                if (chan < 0)
                begin
                        errors++;
                        $display("Error at %0t: bus cycle with no accepted request", $time);
                end
                if (fair_mode && chan >= 0 && chan == last_chan &&
                    (chan == 1 ? exp_c_q.size() : exp_d_q.size()) > 0)
                begin
                        errors++;
                        $display("Error at %0t: channel %0d granted twice while other waits",
                                 $time, chan);
                end
                last_chan = chan;
        endtask

        always @(negedge clk)
        begin
                if (arst_n)
                begin
                        check_rsp("o_code_rsp", nxt_c, code_rsp);
                        check_rsp("o_data_rsp", nxt_d, data_rsp);
                        nxt_c.valid = 1'b0;
                        nxt_d.valid = 1'b0;
                        if (held)
                                check_wb("o_wb", wb_prev, wb);  // Must hold until ack.
                        held    = wb.stb && !wb_ack;
                        wb_prev = wb;
                        if (wb.stb && wb_ack)
                                bus_done();
                        code_fire = code_valid && code_ready;
                        data_fire = data_valid && data_ready;
                        if (code_fire)
                                exp_c_q.push_back('{1'b1, 1'b1, 1'b0, 4'hF,
                                        reloc(code_adr.flat, pid, 1'b1), 32'h0,
                                        zap_bus_pkg::cti_eob, zap_bus_pkg::bte_linear});
                        if (data_fire)
                        begin
                                exp_d_q.push_back('{1'b1, 1'b1, data_req.we, rev_sel(data_req.sel),
                                        reloc(data_req.adr, pid, 1'b0), data_req.dat,
                                        zap_bus_pkg::cti_eob, zap_bus_pkg::bte_linear});
                                core_sel_q.push_back(data_req.sel);
                        end
                end
        end

        // --------------------------------------------------------------------------
        // Test sequence.
        // --------------------------------------------------------------------------

        task automatic run_traffic(input string name, input int nc, input int nd,
                                   input int p, input int maxw, input bit fair,
                                   output bit ok);
                int n;
                ok = 1'b0;
                @(negedge clk);
                code_left = nc;
                data_left = nd;
                pct       = p;
                max_wait  = maxw;
                fair_mode = fair;
                last_chan = -1;
                n = 0;
                while ((code_left > 0 || data_left > 0) && n < 4000)
                begin
                        @(negedge clk);
                        n++;
                end
                if (code_left > 0 || data_left > 0)
                        report_timeout({name, ": requests were not accepted"});
                else
                begin
                        n = 0;
                        while (!idle() && n < 1000)
                        begin
                                @(negedge clk);
                                n++;
                        end
                        if (!idle())
                                report_timeout({name, ": outstanding requests never completed"});
                        else
                                ok = 1'b1;
                end
                fair_mode = 1'b0;
                report_test(name);
        endtask

        initial
        begin
                void'($urandom(32'h184c05eb));
                arst_n     = 1'b0;
                pid        = '0;
                code_valid = 1'b0;
                code_adr   = '0;
                data_valid = 1'b0;
                data_req   = '0;
                wb_ack     = 1'b0;
                wb_dat     = '0;
                nxt_c      = '0;
                nxt_d      = '0;
                repeat (2) @(posedge clk);
                #2;
                check_field("o_wb.cyc", 32'h0, wb.cyc);
                check_field("o_wb.stb", 32'h0, wb.stb);
                check_field("o_wb.cti", 32'h7, wb.cti);
                check_field("o_wb.bte", 32'h0, wb.bte);
                check_field("o_code_ready", 32'h0, code_ready);
                check_field("o_data_ready", 32'h0, data_ready);
                check_field("o_code_rsp.valid", 32'h0, code_rsp.valid);
                check_field("o_data_rsp.valid", 32'h0, data_rsp.valid);
                arst_n = 1'b1;
                report_test("reset state");
                run_traffic("mixed traffic", 40, 40, 50, 4, 1'b0, run_ok);
                if (run_ok)
                        run_traffic("back-pressure", 30, 30, 90, 12, 1'b0, run_ok);
                if (run_ok)
                        run_traffic("fairness", 30, 30, 100, 4, 1'b1, run_ok);
                end_run();
        end

endmodule
